// File: source/mod_arith_pkg.sv
`default_nettype none

package mod_arith_pkg;

  // Operand, modulus and mu width
  localparam int unsigned DATA_W = 32;

  // Products and REDUCE inputs
  localparam int unsigned WIDE_W = 2 * DATA_W;

  // Holds a bit length up to DATA_W
  localparam int unsigned BL_W = 6;

  // Largest k for which mu = floor(4^k / m) still fits in DATA_W.
  // With m >= 2^(k-1), mu reaches 2^(k+1), so k must stay at DATA_W - 2.
  localparam int unsigned MAX_MOD_BL = DATA_W - 2;

endpackage : mod_arith_pkg

`default_nettype wire

// File: source/mod_cmd_pkg.sv
`default_nettype none

package mod_cmd_pkg;

  import mod_arith_pkg::*;

  typedef enum logic [2:0] {
    OP_SET_MOD = 3'd0,  // a = m, b = mu
    OP_REDUCE  = 3'd1,  // x = {a, b}
    OP_MULMOD  = 3'd2,
    OP_ADDMOD  = 3'd3
  } mod_op_e;

  typedef struct packed {
    mod_op_e             opcode;
    logic [DATA_W-1:0]   a;
    logic [DATA_W-1:0]   b;
  } mod_cmd_t;

  typedef struct packed {
    mod_op_e             opcode;
    logic [DATA_W-1:0]   a;
    logic [DATA_W-1:0]   b;
    logic                err;        // Illegal opcode or no context
  } mod_dec_t;

  typedef struct packed {
    logic [DATA_W-1:0]   m;
    logic [DATA_W-1:0]   mu;
    logic [BL_W-1:0]     k;          // Bit length of m
    logic                ctx_valid;
  } mod_ctx_t;

  typedef struct packed {
    logic [WIDE_W-1:0]   x;
    logic [WIDE_W-1:0]   qm;         // Quotient estimate times m
    logic [DATA_W-1:0]   m;
    logic                err;
  } mod_part_t;

  typedef struct packed {
    logic [DATA_W-1:0]   data;
    logic                err;
  } mod_res_t;

endpackage : mod_cmd_pkg

`default_nettype wire

// File: source/mod_decode.sv
`default_nettype none

module mod_decode (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   advance_i,    // Pipeline step enable
  input  logic                   cmd_valid_i,
  input  mod_cmd_pkg::mod_cmd_t  cmd_i,
  output logic                   dec_valid_o,
  output mod_cmd_pkg::mod_dec_t  dec_o,
  output mod_cmd_pkg::mod_ctx_t  ctx_o         // Modulus context
);

  import mod_arith_pkg::*;
  import mod_cmd_pkg::*;

  logic            accept;
  logic            is_set;
  logic            op_legal;
  logic [BL_W-1:0] new_k;
  logic            k_ok;
  logic            dec_valid_q;
  mod_dec_t        dec_q;
  mod_ctx_t        ctx_q;

  // Position of the leading one, plus one
  function automatic logic [BL_W-1:0] bit_len(input logic [DATA_W-1:0] v);
    logic [BL_W-1:0] len;
    len = '0;
    for (int i = 0; i < DATA_W; i++) begin
      if (v[i]) len = BL_W'(i + 1);
    end
    return len;
  endfunction

  assign accept = cmd_valid_i && advance_i;
  assign is_set = (cmd_i.opcode == OP_SET_MOD);

  always_comb begin
    case (cmd_i.opcode)
      OP_REDUCE, OP_MULMOD, OP_ADDMOD: op_legal = 1'b1;
      default:                         op_legal = 1'b0;  // Includes SET_MOD
    endcase
  end

  assign new_k = bit_len(cmd_i.a);
  assign k_ok  = (new_k >= BL_W'(2)) && (new_k <= BL_W'(MAX_MOD_BL));  // m of 0 or 1 rejected

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctx_q <= '0;
    end else if (accept && is_set) begin
      if (k_ok) begin
        ctx_q <= '{m: cmd_i.a, mu: cmd_i.b, k: new_k, ctx_valid: 1'b1};
      end else begin
        ctx_q.ctx_valid <= 1'b0;     // Bad modulus drops the old one too
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid_q <= 1'b0;
    end else if (advance_i) begin
      dec_valid_q <= cmd_valid_i && !is_set;  // SET_MOD leaves no result
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance_i) begin
      dec_q <= '{opcode: cmd_i.opcode,
                 a:      cmd_i.a,
                 b:      cmd_i.b,
                 err:    !op_legal || !ctx_q.ctx_valid};
    end
  end

  assign dec_valid_o = dec_valid_q;
  assign dec_o       = dec_q;
  assign ctx_o       = ctx_q;

  // Decode output must hold while the pipeline is stalled
  a_dec_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !advance_i |=> $stable(dec_valid_o) && (!dec_valid_o || $stable(dec_o)))
    else $error("decode output changed during stall");

endmodule : mod_decode

`default_nettype wire

// File: source/mod_execute.sv
`default_nettype none

module mod_execute (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    advance_i,
  input  logic                    dec_valid_i,
  input  mod_cmd_pkg::mod_dec_t   dec_i,
  input  mod_cmd_pkg::mod_ctx_t   ctx_i,       // Sampled on entry
  output logic                    part_valid_o,
  output mod_cmd_pkg::mod_part_t  part_o
);

  import mod_arith_pkg::*;
  import mod_cmd_pkg::*;

  // Stage one
  logic [WIDE_W-1:0] x_sel;
  logic              v1_q;
  logic [WIDE_W-1:0] x1_q;
  logic [DATA_W-1:0] m1_q;
  logic [DATA_W-1:0] mu1_q;
  logic [BL_W-1:0]   k1_q;
  logic              err1_q;
  logic              red1_q;       // REDUCE, for the range check

  // Stage two
  logic [BL_W-1:0]   sh_lo;
  logic [BL_W-1:0]   sh_hi;
  logic [WIDE_W-1:0] x_sh;
  logic [WIDE_W-1:0] q_prod;
  logic [WIDE_W-1:0] q_est;
  logic [WIDE_W-1:0] qm;
  logic              v2_q;
  mod_part_t         part_q;

  always_comb begin
    case (dec_i.opcode)
      OP_MULMOD: x_sel = WIDE_W'(dec_i.a) * WIDE_W'(dec_i.b);
      OP_ADDMOD: x_sel = WIDE_W'(dec_i.a) + WIDE_W'(dec_i.b);
      OP_REDUCE: x_sel = {dec_i.a, dec_i.b};
      default:   x_sel = '0;           // Illegal op, err already set
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      v1_q <= 1'b0;
      v2_q <= 1'b0;
    end else if (advance_i) begin
      v1_q <= dec_valid_i;
      v2_q <= v1_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance_i) begin
      x1_q   <= x_sel;
      m1_q   <= ctx_i.m;
      mu1_q  <= ctx_i.mu;
      k1_q   <= ctx_i.k;
      err1_q <= dec_i.err;
      red1_q <= (dec_i.opcode == OP_REDUCE);
    end
  end

  // q = ((x >> (k-1)) * mu) >> (k+1)
  always_comb begin
    sh_lo  = k1_q - BL_W'(1);
    sh_hi  = k1_q + BL_W'(1);
    x_sh   = x1_q >> sh_lo;              // Below 2^(k+1) for legal x
    q_prod = WIDE_W'(x_sh[DATA_W-1:0]) * WIDE_W'(mu1_q);
    q_est  = q_prod >> sh_hi;
    qm     = WIDE_W'(q_est[DATA_W-1:0]) * WIDE_W'(m1_q);
  end

  always_ff @(posedge clk_i) begin
    if (advance_i) begin
      part_q <= '{x: x1_q, qm: qm, m: m1_q, err: err1_q};
    end
  end

  assign part_valid_o = v2_q;
  assign part_o       = part_q;

  // Barrett bound needs x < m^2; host must keep REDUCE inputs in range
  a_reduce_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    v1_q && red1_q && !err1_q |-> x1_q < WIDE_W'(m1_q) * WIDE_W'(m1_q))
    else $error("REDUCE input not below m squared");

endmodule : mod_execute

`default_nettype wire

// File: source/mod_result.sv
`default_nettype none

module mod_result (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    part_valid_i,
  input  mod_cmd_pkg::mod_part_t  part_i,
  input  logic                    res_ready_i,
  output logic                    res_valid_o,
  output mod_cmd_pkg::mod_res_t   res_o,
  output logic                    advance_o      // Whole pipeline steps
);

  import mod_arith_pkg::*;
  import mod_cmd_pkg::*;

  logic [WIDE_W-1:0] m_w;
  logic [WIDE_W-1:0] r0;
  logic [WIDE_W-1:0] r1;
  logic [WIDE_W-1:0] r2;
  logic              res_valid_q;
  mod_res_t          res_q;

  assign m_w = WIDE_W'(part_i.m);

  // Estimate is at most two short, so two conditional subtractions
  always_comb begin
    r0 = part_i.x - part_i.qm;
    r1 = (r0 >= m_w) ? r0 - m_w : r0;
    r2 = (r1 >= m_w) ? r1 - m_w : r1;
  end

  // Empty or drained this cycle
  assign advance_o = !res_valid_q || res_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
    end else if (advance_o) begin
      res_valid_q <= part_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance_o) begin
      res_q.data <= part_i.err ? '0 : r2[DATA_W-1:0];
      res_q.err  <= part_i.err;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_o       = res_q;

  a_res_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o))
    else $error("result changed under back-pressure");

  // Catches a bad mu from the host or a broken quotient stage
  a_rem_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    part_valid_i && !part_i.err |-> r0 < 3 * m_w)
    else $error("remainder before correction not below 3m");

endmodule : mod_result

`default_nettype wire

// File: source/mod_unit_top.sv
`default_nettype none

module mod_unit_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  input  mod_cmd_pkg::mod_cmd_t  cmd_i,
  output logic                   res_valid_o,
  input  logic                   res_ready_i,
  output mod_cmd_pkg::mod_res_t  res_o
);

  import mod_cmd_pkg::*;

  logic      advance;     // From the result stage
  logic      dec_valid;
  mod_dec_t  dec;
  mod_ctx_t  ctx;
  logic      part_valid;
  mod_part_t part;

  assign cmd_ready_o = advance;

  mod_decode u_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .advance_i   (advance),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .dec_valid_o (dec_valid),
    .dec_o       (dec),
    .ctx_o       (ctx)
  );

  mod_execute u_execute (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .advance_i    (advance),
    .dec_valid_i  (dec_valid),
    .dec_i        (dec),
    .ctx_i        (ctx),
    .part_valid_o (part_valid),
    .part_o       (part)
  );

  mod_result u_result (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .part_valid_i (part_valid),
    .part_i       (part),
    .res_ready_i  (res_ready_i),
    .res_valid_o  (res_valid_o),
    .res_o        (res_o),
    .advance_o    (advance)
  );

endmodule : mod_unit_top

`default_nettype wire

// File: dv/mod_unit_tb.sv
`default_nettype none

module mod_unit_tb;

  import mod_arith_pkg::*;
  import mod_cmd_pkg::*;

  localparam int WAIT_LIMIT = 200;  // Cycles per wait loop

  logic        clk_i;
  logic        rst_ni;
  logic        cmd_valid_i;
  logic        cmd_ready_o;
  mod_cmd_t    cmd_i;
  logic        res_valid_o;
  logic        res_ready_i;
  mod_res_t    res_o;

  int          seed = 32032;
  int          errors = 0;
  int          arith_cnt = 0;     // Accepted non-SET_MOD commands
  int          res_cnt = 0;       // Results taken
  logic        bp_on = 1'b0;      // Random back-pressure enable
  int          stretch = 0;
  logic [31:0] cur_m = 32'd1000;  // Operand bound for stimulus

  // Reference model state
  mod_res_t    exp_q[$];
  mod_res_t    exp_head = '0;
  int          exp_cnt = 0;
  logic        model_ok = 1'b0;
  logic [31:0] model_m = '0;

  mod_unit_top u_mod_unit_top (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_i       (cmd_i),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_o       (res_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  // True remainder, or err for an illegal op or no modulus
  function automatic mod_res_t expected_result(input mod_cmd_t c, input logic ok,
                                               input logic [31:0] m);
    logic [63:0] x;
    if (!ok || !(c.opcode inside {OP_REDUCE, OP_MULMOD, OP_ADDMOD})) begin
      return '{data: '0, err: 1'b1};
    end
    case (c.opcode)
      OP_MULMOD: x = 64'(c.a) * 64'(c.b);
      OP_ADDMOD: x = 64'(c.a) + 64'(c.b);
      default:   x = {c.a, c.b};
    endcase
    return '{data: DATA_W'(x % 64'(m)), err: 1'b0};
  endfunction

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (res_valid_o && res_ready_i) begin
        res_cnt++;
        if (exp_q.size() > 0) void'(exp_q.pop_front());
      end
      if (cmd_valid_i && cmd_ready_o) begin
        if (cmd_i.opcode == OP_SET_MOD) begin
          model_ok = (cmd_i.a >= 32'd2) && (cmd_i.a < (32'd1 << MAX_MOD_BL));
          if (model_ok) model_m = cmd_i.a;
        end else begin
          exp_q.push_back(expected_result(cmd_i, model_ok, model_m));
          arith_cnt++;
        end
      end
      exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
      exp_cnt  <= exp_q.size();
    end
  end

  a_no_orphan: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o |-> exp_cnt != 0)
    else begin
      errors++;
      $display("Result valid at %0t with no command pending", $time);
    end

  a_data_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o && res_ready_i && exp_cnt != 0 |-> res_o == exp_head)
    else begin
      errors++;
      $display("Fail at %0t: res_o got data=%h err=%b, expected data=%h err=%b", $time,
               $sampled(res_o.data), $sampled(res_o.err),
               $sampled(exp_head.data), $sampled(exp_head.err));
    end

  a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o))
    else begin
      errors++;
      $display("Result changed or dropped at %0t while res_ready_i was low", $time);
    end

  a_stall_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o && !res_ready_i |-> !cmd_ready_o)
    else begin
      errors++;
      $display("cmd_ready_o high at %0t during back-pressure", $time);
    end

  // Accepted at edge N, valid from edge N+4
  a_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_i && cmd_ready_o && cmd_i.opcode != OP_SET_MOD ##1 res_ready_i [*3]
    |=> res_valid_o)
    else begin
      errors++;
      $display("No result four cycles after the command accepted before %0t", $time);
    end

  task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting for %s, %0d errors so far", what, errors);
    $display("=== FAIL ===");
    $finish;
  endtask

  // Steps to 10 units after the next rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #10;
    if (!bp_on) begin
      res_ready_i = 1'b1;
    end else if (stretch == 0) begin
      res_ready_i = !res_ready_i;
      stretch = int'(rand32() % 32'd6);
    end else begin
      stretch--;
    end
  endtask

  task automatic send_cmd(input mod_op_e op, input logic [31:0] a, input logic [31:0] b);
    int   waited;
    logic rdy;
    cmd_valid_i = 1'b1;
    cmd_i = '{opcode: op, a: a, b: b};
    waited = 0;
    rdy = 1'b0;
    while (!rdy && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      rdy = cmd_ready_o;
      next_cycle();
      waited++;
    end
    cmd_valid_i = 1'b0;
    if (!rdy) stop_on_timeout("cmd_ready_o");
  endtask

  task automatic load_modulus();
    int          k;
    logic [63:0] mu;
    k = 2 + int'(rand32() % 32'(MAX_MOD_BL - 1));
    cur_m = (32'd1 << (k - 1)) | (rand32() & ((32'd1 << (k - 1)) - 32'd1));
    mu = (64'd1 << (2 * k)) / 64'(cur_m);  // floor(4^k / m)
    send_cmd(OP_SET_MOD, cur_m, mu[31:0]);
  endtask

  task automatic send_random_op(input logic [31:0] m);
    logic [63:0] x;
    int          r;
    r = int'(rand32() % 32'd16);
    if (r == 0) begin
      send_cmd(mod_op_e'(3'd4 + 3'(rand32() % 32'd4)), rand32(), rand32());
    end else if (r < 6) begin
      x = {rand32(), rand32()} % (64'(m) * 64'(m));  // Below m squared
      send_cmd(OP_REDUCE, x[63:32], x[31:0]);
    end else if (r < 11) begin
      send_cmd(OP_MULMOD, rand32() % m, rand32() % m);
    end else begin
      send_cmd(OP_ADDMOD, rand32() % m, rand32() % m);
    end
  endtask

  initial begin
    int waited;
    cmd_valid_i = 1'b0;
    cmd_i = '0;
    res_ready_i = 1'b1;
    rst_ni = 1'b0;
    repeat (10) @(posedge clk_i);
    #10 rst_ni = 1'b1;
    assert (cmd_ready_o && !res_valid_o)
      else begin
        errors++;
        $display("Wrong handshake state after reset");
      end

    repeat (4) send_random_op(cur_m);          // No context yet
    send_cmd(OP_SET_MOD, 32'd1, 32'd0);        // m below 2
    repeat (2) send_random_op(cur_m);
    send_cmd(OP_SET_MOD, 32'd0, 32'd0);
    send_random_op(cur_m);
    send_cmd(OP_SET_MOD, 32'h4000_0000, 32'd4);  // Bit length 31
    repeat (2) send_random_op(cur_m);

    for (int round = 0; round < 12; round++) begin
      bp_on = (round >= 6);                    // Steady ready first
      load_modulus();
      repeat (16) send_random_op(cur_m);
    end

    bp_on = 1'b0;
    send_cmd(OP_SET_MOD, 32'hffff_ffff, 32'd0);  // Drops the valid context
    repeat (3) send_random_op(cur_m);
    load_modulus();
    repeat (4) send_random_op(cur_m);

    waited = 0;
    while (exp_cnt != 0 && waited < WAIT_LIMIT) begin
      next_cycle();
      waited++;
    end
    if (exp_cnt != 0) stop_on_timeout("the last results");
    repeat (8) next_cycle();                   // Catch stray extra results

    assert (res_cnt == arith_cnt)
      else begin
        errors++;
        $display("Result count %0d differs from command count %0d", res_cnt, arith_cnt);
      end
    $display("Run finished with %0d errors, %0d commands, %0d results",
             errors, arith_cnt, res_cnt);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule : mod_unit_tb

`default_nettype wire

// File: src.f
source/mod_arith_pkg.sv
source/mod_cmd_pkg.sv
source/mod_decode.sv
source/mod_execute.sv
source/mod_result.sv
source/mod_unit_top.sv
dv/mod_unit_tb.sv
